//--- ahb_mem_sys.f
rtl/mem_sys_pkg.sv
rtl/ahb_pma_decoder.sv
rtl/ahb_ram.sv
rtl/mmio_catch.sv
rtl/ahb_mem_sys.sv
bench/ahb_mem_sys_sva.sv
bench/ahb_mem_sys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f ahb_mem_sys.f \
  --top-module ahb_mem_sys_tb \
  -Mdir obj_dir

./obj_dir/Vahb_mem_sys_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Run failed"
  exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
  echo "Run ended without a result"
  exit 1
fi

echo "Run passed"

//--- bench/ahb_mem_sys_tb.sv
/*
 * Testbench for the data-port memory subsystem, a table-driven
 * AHB-Lite master with pipelined transfers and MMIO checks
 */
`timescale 1ns/10ps

module ahb_mem_sys_tb;
  import mem_sys_pkg::*;

  typedef enum logic [1:0] {FX_NONE, FX_TOHOST, FX_UART} fx_e;

  typedef struct packed {
    logic               wr;
    logic               fetch;
    logic [HADDR_W-1:0] addr;
    hsize_e             size;
    logic [HDATA_W-1:0] wdata;
    hresp_e             resp;
    logic [HDATA_W-1:0] rdata;
    fx_e                fx;
  } entry_t;

  localparam int NUM         = 21;
  localparam int WATCHDOG_NS = (NUM * 8 + 20) * 40;

  logic                                HCLK;
  logic                                rst_i;
  pma_cfg_t [PMA_CNT-1:0]              pma_cfg_i;
  logic [PMA_CNT-1:0][HADDR_W-1:0]     pma_adr_i;
  ahb_ctrl_t                           m_ctrl_i;
  logic [HDATA_W-1:0]                  m_hwdata_i;
  ahb_rsp_t                            m_rsp_o;
  logic [HDATA_W-1:0]                  tohost_o;
  logic                                tohost_valid_o;
  logic [7:0]                          uart_data_o;
  logic                                uart_valid_o;

  entry_t tbl [NUM];
  int     seed;

  // Expected MMIO state
  logic [HDATA_W-1:0] exp_tohost;
  logic               exp_tv;
  logic [7:0]         exp_uart;
  logic               exp_uv;

  ahb_mem_sys i_ahb_mem_sys (
    .HCLK           ( HCLK           ),
    .rst_i          ( rst_i          ),
    .pma_cfg_i      ( pma_cfg_i      ),
    .pma_adr_i      ( pma_adr_i      ),
    .m_ctrl_i       ( m_ctrl_i       ),
    .m_hwdata_i     ( m_hwdata_i     ),
    .m_rsp_o        ( m_rsp_o        ),
    .tohost_o       ( tohost_o       ),
    .tohost_valid_o ( tohost_valid_o ),
    .uart_data_o    ( uart_data_o    ),
    .uart_valid_o   ( uart_valid_o   )
  );

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the transfer table did not complete in time");
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("Error: %0t: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_resp(input int n, input hresp_e exp, input hresp_e got);
    if (got !== exp) begin
      stop_run($sformatf("entry %0d hresp %s, expected %s", n, got.name(), exp.name()));
    end
  endtask

  task automatic check_rdata(input int n, input logic [HDATA_W-1:0] exp,
                             input logic [HDATA_W-1:0] got);
    if (got !== exp) begin
      stop_run($sformatf("entry %0d hrdata %h, expected %h", n, got, exp));
    end
  endtask

  task automatic check_mmio(input logic [HDATA_W-1:0] exp_word, input logic exp_wv,
                            input logic [7:0] exp_byte, input logic exp_bv);
    if (tohost_valid_o !== exp_wv || (exp_wv && tohost_o !== exp_word)) begin
      stop_run($sformatf("tohost %h valid %b, expected %h valid %b",
                         tohost_o, tohost_valid_o, exp_word, exp_wv));
    end
    if (uart_valid_o !== exp_bv || (exp_bv && uart_data_o !== exp_byte)) begin
      stop_run($sformatf("uart %h valid %b, expected %h valid %b",
                         uart_data_o, uart_valid_o, exp_byte, exp_bv));
    end
  endtask

  function automatic entry_t mk(input logic wr, input logic fetch, input logic [31:0] addr,
                                input hsize_e size, input logic [31:0] wdata,
                                input hresp_e resp, input logic [31:0] rdata, input fx_e fx);
    mk = '{wr, fetch, addr, size, wdata, resp, rdata, fx};
  endfunction

  ////////////////////////////////////////////////////////////
  // Transfer table
  ////////////////////////////////////////////////////////////

  task automatic load_table();
    // Region 3 words, then lane merges at 0x1104
    tbl[0]  = mk(1, 0, 32'h1100, HSIZE_WORD, 32'h1122_3344, HRESP_OKAY, 0, FX_NONE);
    tbl[1]  = mk(0, 0, 32'h1100, HSIZE_WORD, 0, HRESP_OKAY, 32'h1122_3344, FX_NONE);
    tbl[2]  = mk(1, 0, 32'h1104, HSIZE_WORD, 32'hA5A5_5A5A, HRESP_OKAY, 0, FX_NONE);
    tbl[3]  = mk(0, 0, 32'h1104, HSIZE_WORD, 0, HRESP_OKAY, 32'hA5A5_5A5A, FX_NONE);
    tbl[4]  = mk(1, 0, 32'h1105, HSIZE_BYTE, 32'hDEAD_7EEF, HRESP_OKAY, 0, FX_NONE);
    tbl[5]  = mk(1, 0, 32'h1106, HSIZE_HALF, 32'h1234_BEEF, HRESP_OKAY, 0, FX_NONE);
    tbl[6]  = mk(0, 0, 32'h1104, HSIZE_WORD, 0, HRESP_OKAY, 32'h1234_7E5A, FX_NONE);
    // Region 0 is read and execute only, aliases region 3
    tbl[7]  = mk(1, 0, 32'h0100, HSIZE_WORD, 32'hFFFF_FFFF, HRESP_ERROR, 0, FX_NONE);
    tbl[8]  = mk(0, 0, 32'h0100, HSIZE_WORD, 0, HRESP_OKAY, 32'h1122_3344, FX_NONE);
    tbl[9]  = mk(0, 1, 32'h0104, HSIZE_WORD, 0, HRESP_OKAY, 32'h1234_7E5A, FX_NONE);
    // MMIO regions
    tbl[10] = mk(0, 1, 32'h1000, HSIZE_WORD, 0, HRESP_ERROR, 0, FX_NONE);
    tbl[11] = mk(1, 0, 32'h1000, HSIZE_WORD, 32'hCAFE_0001, HRESP_OKAY, 0, FX_TOHOST);
    tbl[12] = mk(0, 0, 32'h1000, HSIZE_WORD, 0, HRESP_OKAY, 32'hCAFE_0001, FX_NONE);
    tbl[13] = mk(0, 0, 32'h1080, HSIZE_WORD, 0, HRESP_ERROR, 0, FX_NONE);
    tbl[14] = mk(1, 0, 32'h1080, HSIZE_WORD, 32'h0000_0041, HRESP_OKAY, 0, FX_UART);
    // Unmapped and no-execute accesses
    // 0x2100 shares its RAM word with 0x1100
    tbl[15] = mk(1, 0, 32'h2100, HSIZE_WORD, 32'h5555_AAAA, HRESP_ERROR, 0, FX_NONE);
    tbl[16] = mk(0, 0, 32'h2004, HSIZE_WORD, 0, HRESP_ERROR, 0, FX_NONE);
    tbl[17] = mk(0, 0, 32'h1100, HSIZE_WORD, 0, HRESP_OKAY, 32'h1122_3344, FX_NONE);
    tbl[18] = mk(1, 0, 32'h1080, HSIZE_BYTE, 32'h0000_005A, HRESP_OKAY, 0, FX_UART);
    tbl[19] = mk(0, 0, 32'h1040, HSIZE_WORD, 0, HRESP_ERROR, 0, FX_NONE);
    tbl[20] = mk(0, 1, 32'h1100, HSIZE_WORD, 0, HRESP_ERROR, 0, FX_NONE);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int idx;
    int dp;
    int nxt;
    int gap;

    seed       = 60986;
    rst_i      = 1'b1;
    m_ctrl_i   = '0;
    m_hwdata_i = '0;
    exp_tohost = '0;
    exp_tv     = 1'b0;
    exp_uart   = '0;
    exp_uv     = 1'b0;
    // Addresses shifted right by two, as in PMP
    pma_cfg_i[0] = '{MEM_MAIN, 1'b1, 1'b0, 1'b1, PMA_TOR};
    pma_adr_i[0] = 32'h0000_0400;
    pma_cfg_i[1] = '{MEM_IO, 1'b1, 1'b1, 1'b0, PMA_NAPOT};
    pma_adr_i[1] = 32'h0000_0407;
    pma_cfg_i[2] = '{MEM_IO, 1'b0, 1'b1, 1'b0, PMA_NA4};
    pma_adr_i[2] = 32'h0000_0420;
    pma_cfg_i[3] = '{MEM_MAIN, 1'b1, 1'b1, 1'b0, PMA_TOR};
    pma_adr_i[3] = 32'h0000_0800;
    load_table();

    repeat (5) @(negedge HCLK);
    rst_i = 1'b0;

    idx = 0;
    dp  = -1;
    nxt = -1;
    gap = 0;
    while (idx < NUM || nxt >= 0 || dp >= 0) begin
      @(negedge HCLK);
      check_mmio(exp_tohost, exp_tv, exp_uart, exp_uv);
      exp_uv = 1'b0;
      // Address accepted at the last edge starts its data phase
      if (nxt >= 0) begin
        dp         = nxt;
        nxt        = -1;
        m_hwdata_i = tbl[dp].wdata;
      end
      // hreadyout comes from registers only, stable here
      if (m_rsp_o.hreadyout) begin
        if (dp >= 0) begin
          check_resp(dp, tbl[dp].resp, m_rsp_o.hresp);
          if (!tbl[dp].wr && tbl[dp].resp == HRESP_OKAY) begin
            check_rdata(dp, tbl[dp].rdata, m_rsp_o.hrdata);
          end
          if (tbl[dp].fx == FX_TOHOST) begin
            exp_tohost = tbl[dp].wdata;
            exp_tv     = 1'b1;
          end else if (tbl[dp].fx == FX_UART) begin
            exp_uart = tbl[dp].wdata[7:0];
            exp_uv   = 1'b1;
          end
          dp = -1;
        end
        if (idx < NUM && gap == 0) begin
          m_ctrl_i.hsel   = 1'b1;
          m_ctrl_i.haddr  = tbl[idx].addr;
          m_ctrl_i.hwrite = tbl[idx].wr;
          m_ctrl_i.hsize  = tbl[idx].size;
          m_ctrl_i.htrans = HTRANS_NONSEQ;
          m_ctrl_i.hprot  = !tbl[idx].fetch;
          nxt = idx;
          idx++;
          gap = int'($unsigned($random(seed)) % 3);
        end else begin
          m_ctrl_i.htrans = HTRANS_IDLE;
          m_ctrl_i.hwrite = 1'b0;
          if (gap > 0) begin
            gap--;
          end
        end
      end
    end

    // Last MMIO effect shows one cycle after its data phase
    @(negedge HCLK);
    check_mmio(exp_tohost, exp_tv, exp_uart, exp_uv);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- bench/ahb_mem_sys_sva.sv
/*
 * Response protocol checks for the PMA decoder, bound into every instance
 */
`timescale 1ns/10ps

module ahb_mem_sys_sva (
  input logic                   HCLK,
  input logic                   rst_i,
  input mem_sys_pkg::ahb_ctrl_t m_ctrl_i,
  input logic                   hready_o,
  input mem_sys_pkg::ahb_rsp_t  m_rsp_o
);
  import mem_sys_pkg::*;

  // Bus is ready and OKAY in the cycle after reset
  a_reset_ready: assert property (@(posedge HCLK)
    rst_i |=> (m_rsp_o.hreadyout && m_rsp_o.hresp == HRESP_OKAY))
    else $error("decoder not ready with OKAY after reset");

  // First ERROR cycle is followed by the closing ERROR cycle
  a_err_second: assert property (@(posedge HCLK) disable iff (rst_i)
    (m_rsp_o.hresp == HRESP_ERROR && !m_rsp_o.hreadyout)
    |=> (m_rsp_o.hresp == HRESP_ERROR && m_rsp_o.hreadyout))
    else $error("ERROR response without its second cycle");

  // Closing ERROR cycle always has a first cycle before it
  a_err_first: assert property (@(posedge HCLK) disable iff (rst_i)
    (m_rsp_o.hresp == HRESP_ERROR && m_rsp_o.hreadyout)
    |-> $past(m_rsp_o.hresp == HRESP_ERROR && !m_rsp_o.hreadyout))
    else $error("ERROR response shorter than two cycles");

  // Idle or unselected address phase gets OKAY with zero wait
  a_idle_okay: assert property (@(posedge HCLK) disable iff (rst_i)
    (hready_o && (!m_ctrl_i.hsel || m_ctrl_i.htrans == HTRANS_IDLE))
    |=> (m_rsp_o.hreadyout && m_rsp_o.hresp == HRESP_OKAY))
    else $error("idle transfer not answered with OKAY");

endmodule

bind ahb_pma_decoder ahb_mem_sys_sva i_ahb_mem_sys_sva (
  .HCLK     ( HCLK     ),
  .rst_i    ( rst_i    ),
  .m_ctrl_i ( m_ctrl_i ),
  .hready_o ( hready_o ),
  .m_rsp_o  ( m_rsp_o  )
);

//--- rtl/ahb_mem_sys.sv
/*
 * Data-port memory subsystem: PMA decoder in front of the RAM
 * and the MMIO catcher
 */
`timescale 1ns/10ps

module ahb_mem_sys (
  input  logic                                                      HCLK,
  input  logic                                                      rst_i,
  input  mem_sys_pkg::pma_cfg_t [mem_sys_pkg::PMA_CNT-1:0]          pma_cfg_i,
  input  logic [mem_sys_pkg::PMA_CNT-1:0][mem_sys_pkg::HADDR_W-1:0] pma_adr_i,
  input  mem_sys_pkg::ahb_ctrl_t                                    m_ctrl_i,
  input  logic [mem_sys_pkg::HDATA_W-1:0]                           m_hwdata_i,
  output mem_sys_pkg::ahb_rsp_t                                     m_rsp_o,
  output logic [mem_sys_pkg::HDATA_W-1:0]                           tohost_o,
  output logic                                                      tohost_valid_o,
  output logic [7:0]                                                uart_data_o,
  output logic                                                      uart_valid_o
);
  import mem_sys_pkg::*;

  // Per-slave address phases and responses
  ahb_ctrl_t ram_ctrl;
  ahb_ctrl_t io_ctrl;
  ahb_rsp_t  ram_rsp;
  ahb_rsp_t  io_rsp;
  // Common HREADY back to both slaves
  logic      hready;

  ahb_pma_decoder i_ahb_pma_decoder (
    .HCLK       ( HCLK      ),
    .rst_i      ( rst_i     ),
    .pma_cfg_i  ( pma_cfg_i ),
    .pma_adr_i  ( pma_adr_i ),
    .m_ctrl_i   ( m_ctrl_i  ),
    .ram_ctrl_o ( ram_ctrl  ),
    .io_ctrl_o  ( io_ctrl   ),
    .hready_o   ( hready    ),
    .ram_rsp_i  ( ram_rsp   ),
    .io_rsp_i   ( io_rsp    ),
    .m_rsp_o    ( m_rsp_o   )
  );

  ahb_ram #(
    .WORDS ( RAM_WORDS ),
    .WAIT  ( RAM_WAIT  )
  ) i_ahb_ram (
    .HCLK     ( HCLK       ),
    .rst_i    ( rst_i      ),
    .ctrl_i   ( ram_ctrl   ),
    .hready_i ( hready     ),
    .hwdata_i ( m_hwdata_i ),
    .rsp_o    ( ram_rsp    )
  );

  mmio_catch i_mmio_catch (
    .HCLK           ( HCLK           ),
    .rst_i          ( rst_i          ),
    .ctrl_i         ( io_ctrl        ),
    .hready_i       ( hready         ),
    .hwdata_i       ( m_hwdata_i     ),
    .rsp_o          ( io_rsp         ),
    .tohost_o       ( tohost_o       ),
    .tohost_valid_o ( tohost_valid_o ),
    .uart_data_o    ( uart_data_o    ),
    .uart_valid_o   ( uart_valid_o   )
  );

endmodule

//--- rtl/mmio_catch.sv
/*
 * AHB-Lite IO slave, catches tohost writes and UART transmit bytes
 */
`timescale 1ns/10ps

module mmio_catch (
  input  logic                            HCLK,
  input  logic                            rst_i,
  input  mem_sys_pkg::ahb_ctrl_t          ctrl_i,
  input  logic                            hready_i,
  input  logic [mem_sys_pkg::HDATA_W-1:0] hwdata_i,
  output mem_sys_pkg::ahb_rsp_t           rsp_o,
  output logic [mem_sys_pkg::HDATA_W-1:0] tohost_o,
  output logic                            tohost_valid_o,
  output logic [7:0]                      uart_data_o,
  output logic                            uart_valid_o
);
  import mem_sys_pkg::*;

  logic               sel;
  logic               act_q;
  logic               write_q;
  logic [HADDR_W-1:0] adr_q;
  logic               is_tohost;
  logic               is_uart;
  logic               wr_end;

  assign sel = ctrl_i.hsel &&
               (ctrl_i.htrans == HTRANS_NONSEQ || ctrl_i.htrans == HTRANS_SEQ);

  always_ff @(posedge HCLK) begin
    if (hready_i && sel) begin
      write_q <= ctrl_i.hwrite;
      adr_q   <= ctrl_i.haddr;
    end
  end

  // Word-aligned register decode
  assign is_tohost = (adr_q[HADDR_W-1:2] == TOHOST_ADR[HADDR_W-1:2]);
  assign is_uart   = (adr_q[HADDR_W-1:2] == UART_TX_ADR[HADDR_W-1:2]);

  // Zero wait, so every data phase ends in its first cycle
  assign wr_end = act_q && write_q;

  always_ff @(posedge HCLK) begin
    if (rst_i) begin
      act_q          <= 1'b0;
      tohost_o       <= '0;
      tohost_valid_o <= 1'b0;
      uart_valid_o   <= 1'b0;
    end else begin
      if (hready_i) begin
        act_q <= sel;
      end
      // Single pulse right after the UART write completes
      uart_valid_o <= wr_end && is_uart;
      // tohost stays valid until reset
      if (wr_end && is_tohost) begin
        tohost_o       <= hwdata_i;
        tohost_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge HCLK) begin
    if (wr_end && is_uart) begin
      uart_data_o <= hwdata_i[7:0];
    end
  end

  // Only tohost reads back, everything else is zero
  assign rsp_o.hrdata    = (act_q && is_tohost) ? tohost_o : '0;
  assign rsp_o.hreadyout = 1'b1;
  assign rsp_o.hresp     = HRESP_OKAY;

endmodule

//--- rtl/ahb_ram.sv
/*
 * AHB-Lite RAM slave with byte-lane writes and a fixed
 * number of wait states per data phase
 */
`timescale 1ns/10ps

module ahb_ram #(
  parameter int WORDS = mem_sys_pkg::RAM_WORDS,
  parameter int WAIT  = mem_sys_pkg::RAM_WAIT
) (
  input  logic                            HCLK,
  input  logic                            rst_i,
  input  mem_sys_pkg::ahb_ctrl_t          ctrl_i,
  input  logic                            hready_i,
  input  logic [mem_sys_pkg::HDATA_W-1:0] hwdata_i,
  output mem_sys_pkg::ahb_rsp_t           rsp_o
);
  import mem_sys_pkg::*;

  localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;
  localparam int CNT_W = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

  logic [HDATA_W-1:0] mem [WORDS];

  logic              sel;
  logic              act_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              done;
  // Latched address phase
  logic              write_q;
  hsize_e            size_q;
  logic [1:0]        lane_q;
  logic [IDX_W-1:0]  idx_q;
  logic [STRB_W-1:0] be;

  assign sel = ctrl_i.hsel &&
               (ctrl_i.htrans == HTRANS_NONSEQ || ctrl_i.htrans == HTRANS_SEQ);

  // Data phase state, wait counter reloads on every accepted phase
  always_ff @(posedge HCLK) begin
    if (rst_i) begin
      act_q <= 1'b0;
      cnt_q <= '0;
    end else if (hready_i) begin
      act_q <= sel;
      cnt_q <= CNT_W'(WAIT);
    end else if (act_q && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge HCLK) begin
    if (hready_i && sel) begin
      write_q <= ctrl_i.hwrite;
      size_q  <= ctrl_i.hsize;
      lane_q  <= ctrl_i.haddr[1:0];
      idx_q   <= ctrl_i.haddr[IDX_W+1:2];
    end
  end

  // Last cycle of the data phase
  assign done = act_q && (cnt_q == '0);

  // Byte lanes from size and low address bits
  always_comb begin
    case (size_q)
      HSIZE_BYTE: be = STRB_W'(1) << lane_q;
      HSIZE_HALF: be = STRB_W'(3) << {lane_q[1], 1'b0};
      default:    be = '1;
    endcase
  end

  // hwdata is stable for the whole data phase
  always_ff @(posedge HCLK) begin
    if (done && write_q) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (be[b]) begin
          mem[idx_q][8*b +: 8] <= hwdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rsp_o.hrdata    = mem[idx_q];
  assign rsp_o.hreadyout = !act_q || (cnt_q == '0);
  assign rsp_o.hresp     = HRESP_OKAY;

endmodule

//--- rtl/ahb_pma_decoder.sv
/*
 * AHB-Lite PMA decoder: checks every address phase against the PMA
 * table, routes permitted transfers to RAM or MMIO, answers the rest with ERROR
 */
`timescale 1ns/10ps

module ahb_pma_decoder (
  input  logic                                                      HCLK,
  input  logic                                                      rst_i,
  input  mem_sys_pkg::pma_cfg_t [mem_sys_pkg::PMA_CNT-1:0]          pma_cfg_i,
  input  logic [mem_sys_pkg::PMA_CNT-1:0][mem_sys_pkg::HADDR_W-1:0] pma_adr_i,
  input  mem_sys_pkg::ahb_ctrl_t                                    m_ctrl_i,
  output mem_sys_pkg::ahb_ctrl_t                                    ram_ctrl_o,
  output mem_sys_pkg::ahb_ctrl_t                                    io_ctrl_o,
  output logic                                                      hready_o,
  input  mem_sys_pkg::ahb_rsp_t                                     ram_rsp_i,
  input  mem_sys_pkg::ahb_rsp_t                                     io_rsp_i,
  output mem_sys_pkg::ahb_rsp_t                                     m_rsp_o
);
  import mem_sys_pkg::*;

  typedef enum logic [1:0] {IDLE, ERR1, ERR2} err_state_e;
  typedef enum logic [1:0] {OWN_NONE, OWN_RAM, OWN_IO, OWN_ERR} owner_e;

  // Word address, compared against the shifted PMA addresses
  logic [HADDR_W-1:0] word_adr;
  logic [PMA_CNT-1:0] region_hit;
  logic               hit;
  pma_cfg_t           hit_cfg;
  logic               right_ok;
  logic               allowed;
  logic               xfer;
  owner_e             owner_d;
  owner_e             owner_q;
  err_state_e         err_d;
  err_state_e         err_q;

  ////////////////////////////////////////////////////////////
  // Region matching
  ////////////////////////////////////////////////////////////

  assign word_adr = {2'b00, m_ctrl_i.haddr[HADDR_W-1:2]};

  for (genvar i = 0; i < PMA_CNT; i++) begin : g_region
    logic [HADDR_W-1:0] lo_adr;
    logic [HADDR_W-1:0] care;

    // TOR lower bound is the previous entry, zero below entry 0
    if (i == 0) begin : g_first
      assign lo_adr = '0;
    end else begin : g_next
      assign lo_adr = pma_adr_i[i-1];
    end

    // NAPOT: trailing ones plus one more bit are don't care
    assign care = ~(pma_adr_i[i] ^ (pma_adr_i[i] + 1'b1));

    always_comb begin
      case (pma_cfg_i[i].a)
        PMA_TOR:   region_hit[i] = (word_adr >= lo_adr) && (word_adr < pma_adr_i[i]);
        PMA_NA4:   region_hit[i] = (word_adr == pma_adr_i[i]);
        PMA_NAPOT: region_hit[i] = ((word_adr & care) == (pma_adr_i[i] & care));
        default:   region_hit[i] = 1'b0;
      endcase
    end
  end

  // Lowest-numbered hit wins, so scan downwards
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = PMA_CNT - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        hit     = 1'b1;
        hit_cfg = pma_cfg_i[i];
      end
    end
  end

  // Fetch needs x, write needs w, read needs r
  always_comb begin
    if (!m_ctrl_i.hprot) begin
      right_ok = hit_cfg.x;
    end else if (m_ctrl_i.hwrite) begin
      right_ok = hit_cfg.w;
    end else begin
      right_ok = hit_cfg.r;
    end
  end

  assign allowed = hit && (hit_cfg.mem_type != MEM_EMPTY) && right_ok;

  // Active transfer, not yet qualified by HREADY
  assign xfer = m_ctrl_i.hsel &&
                (m_ctrl_i.htrans == HTRANS_NONSEQ || m_ctrl_i.htrans == HTRANS_SEQ);

  ////////////////////////////////////////////////////////////
  // Slave fan-out
  ////////////////////////////////////////////////////////////

  always_comb begin
    ram_ctrl_o      = m_ctrl_i;
    ram_ctrl_o.hsel = m_ctrl_i.hsel && allowed && (hit_cfg.mem_type == MEM_MAIN);
    io_ctrl_o       = m_ctrl_i;
    io_ctrl_o.hsel  = m_ctrl_i.hsel && allowed && (hit_cfg.mem_type == MEM_IO);
  end

  // Data-phase owner of the current address phase
  always_comb begin
    owner_d = OWN_NONE;
    if (xfer) begin
      if (!allowed) begin
        owner_d = OWN_ERR;
      end else if (hit_cfg.mem_type == MEM_MAIN) begin
        owner_d = OWN_RAM;
      end else begin
        owner_d = OWN_IO;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Two-cycle ERROR response
  ////////////////////////////////////////////////////////////

  always_comb begin
    err_d = err_q;
    case (err_q)
      // A new denied transfer may follow right after ERR2
      IDLE, ERR2: err_d = (hready_o && owner_d == OWN_ERR) ? ERR1 : IDLE;
      ERR1:       err_d = ERR2;
      default:    err_d = IDLE;
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (rst_i) begin
      owner_q <= OWN_NONE;
      err_q   <= IDLE;
    end else begin
      err_q <= err_d;
      if (hready_o) begin
        owner_q <= owner_d;
      end
    end
  end

  // Response mux, idle data phase is OKAY with zero wait
  always_comb begin
    m_rsp_o.hrdata    = '0;
    m_rsp_o.hreadyout = 1'b1;
    m_rsp_o.hresp     = HRESP_OKAY;
    case (owner_q)
      OWN_RAM: m_rsp_o = ram_rsp_i;
      OWN_IO:  m_rsp_o = io_rsp_i;
      OWN_ERR: begin
        m_rsp_o.hreadyout = (err_q == ERR2);
        m_rsp_o.hresp     = HRESP_ERROR;
      end
      default: ;
    endcase
  end

  assign hready_o = m_rsp_o.hreadyout;

endmodule

//--- rtl/mem_sys_pkg.sv
/*
 * Memory subsystem package: bus widths, PMA region constants,
 * AHB-Lite enums and the structs shared by the decoder and slaves
 */
package mem_sys_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and memory geometry
  ////////////////////////////////////////////////////////////

  localparam int HADDR_W   = 32;
  localparam int HDATA_W   = 32;
  // Byte lanes per data word
  localparam int STRB_W    = HDATA_W / 8;
  localparam int PMA_CNT   = 4;

  // 1 KiB RAM, indexed by haddr[9:2]
  localparam int RAM_WORDS = 256;
  localparam int RAM_WAIT  = 1;

  // MMIO catcher addresses
  localparam logic [HADDR_W-1:0] TOHOST_ADR  = 32'h0000_1000;
  localparam logic [HADDR_W-1:0] UART_TX_ADR = 32'h0000_1080;

  ////////////////////////////////////////////////////////////
  // AHB-Lite encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_e;

  // Only single transfers up to one word
  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_e;

  ////////////////////////////////////////////////////////////
  // PMA encodings, matching modes as in RISC-V PMP
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PMA_OFF   = 2'b00,
    PMA_TOR   = 2'b01,
    PMA_NA4   = 2'b10,
    PMA_NAPOT = 2'b11
  } pma_match_e;

  typedef enum logic [1:0] {
    MEM_EMPTY = 2'b00,
    MEM_MAIN  = 2'b01,
    MEM_IO    = 2'b10
  } mem_type_e;

  // One region: type, access rights, match mode
  typedef struct packed {
    mem_type_e  mem_type;
    logic       r;
    logic       w;
    logic       x;
    pma_match_e a;
  } pma_cfg_t;

  // Address phase of one transfer
  typedef struct packed {
    logic               hsel;
    logic [HADDR_W-1:0] haddr;
    logic               hwrite;
    hsize_e             hsize;
    htrans_e            htrans;
    // HPROT[0], 0 = opcode fetch, 1 = data
    logic               hprot;
  } ahb_ctrl_t;

  // Slave response
  typedef struct packed {
    logic [HDATA_W-1:0] hrdata;
    logic               hreadyout;
    hresp_e             hresp;
  } ahb_rsp_t;

endpackage
